// File: src/decode_macros.svh
`ifndef DECODE_MACROS_SVH
`define DECODE_MACROS_SVH

// fetch packet geometry
`define DEC_PACKET_BYTES 16
`define DEC_MAX_PREFIXES 3

// pointer and length widths
`define DEC_EIP_WIDTH 32
`define DEC_LEN_WIDTH 8

// recognized prefix bytes
`define DEC_PFX_REP    8'hF3
`define DEC_PFX_OPSIZE 8'h66
// segment overrides
`define DEC_PFX_ES     8'h26
`define DEC_PFX_CS     8'h2E
`define DEC_PFX_SS     8'h36
`define DEC_PFX_DS     8'h3E
`define DEC_PFX_FS     8'h64
`define DEC_PFX_GS     8'h65

`endif

// File: src/decode_pkg.sv
`default_nettype none

package decode_pkg;

    // reduced opcode table classes
    typedef enum logic [2:0] {
        OP_ALU_RM,
        OP_ALU_IMM8,
        OP_ALU_IMM,
        OP_MOV_IMM,
        OP_JMP_REL8,
        OP_JMP_REL,
        OP_NOP,
        OP_UNKNOWN
    } op_class_e;

    // immediate width after the modrm group
    typedef enum logic [1:0] {
        IMM_NONE,
        IMM_8,
        IMM_16,
        IMM_32
    } imm_size_e;

    // displacement width, 32-bit addressing only
    typedef enum logic [1:0] {
        DISP_NONE,
        DISP_8,
        DISP_32
    } disp_size_e;

    // segment register encoding 0..5
    typedef enum logic [2:0] {
        SEG_ES,
        SEG_CS,
        SEG_SS,
        SEG_DS,
        SEG_FS,
        SEG_GS
    } seg_reg_e;

endpackage

`default_nettype wire

// File: src/prefix_decode.sv
`timescale 1ns/10ps
`default_nettype none

`include "decode_macros.svh"

module prefix_decode
    import decode_pkg::*;
(
    // byte 0 in the top bits
    input  logic [0:`DEC_PACKET_BYTES-1][7:0] packet_in,
    output logic [1:0]                        num_prefixes,
    output logic                              is_rep,
    output logic                              is_opsize,
    output logic                              is_seg_override,
    output seg_reg_e                          seg_sel
);

    // stays high until the first non-prefix byte
    logic scanning;

    always_comb begin
        num_prefixes    = 2'd0;
        is_rep          = 1'b0;
        is_opsize       = 1'b0;
        is_seg_override = 1'b0;
        // default data segment
        seg_sel         = SEG_DS;
        scanning        = 1'b1;
        for (int i = 0; i < `DEC_MAX_PREFIXES; i++) begin
            if (scanning) begin
                // later segment bytes overwrite earlier ones
                case (packet_in[i])
                    `DEC_PFX_REP:    is_rep = 1'b1;
                    `DEC_PFX_OPSIZE: is_opsize = 1'b1;
                    `DEC_PFX_ES:     seg_sel = SEG_ES;
                    `DEC_PFX_CS:     seg_sel = SEG_CS;
                    `DEC_PFX_SS:     seg_sel = SEG_SS;
                    `DEC_PFX_DS:     seg_sel = SEG_DS;
                    `DEC_PFX_FS:     seg_sel = SEG_FS;
                    `DEC_PFX_GS:     seg_sel = SEG_GS;
                    default:         scanning = 1'b0;
                endcase
                if (scanning) begin
                    num_prefixes = num_prefixes + 2'd1;
                end
                // any matched byte other than rep/opsize is a segment
                if (scanning && !(packet_in[i] inside {`DEC_PFX_REP, `DEC_PFX_OPSIZE})) begin
                    is_seg_override = 1'b1;
                end
            end
        end
    end

endmodule

`default_nettype wire

// File: src/opcode_decode.sv
`timescale 1ns/10ps
`default_nettype none

`include "decode_macros.svh"

module opcode_decode
    import decode_pkg::*;
(
    input  logic [0:`DEC_PACKET_BYTES-1][7:0] packet_in,
    input  logic [1:0]                        num_prefixes,
    input  logic                              is_opsize,
    output op_class_e                         op_class,
    output imm_size_e                         imm_size,
    output logic                              has_modrm,
    output logic [2:0]                        opcode_reg,
    output logic                              opcode_known
);

    // opcode sits right after the prefixes
    logic [7:0] opcode_byte;

    assign opcode_byte = packet_in[num_prefixes];

    ////////////////////////////////////////
    // class lookup
    ////////////////////////////////////////

    always_comb begin
        case (opcode_byte) inside
            // add/sub/xor/mov between reg and r/m
            8'h01, 8'h03, 8'h29, 8'h2B,
            8'h31, 8'h33, 8'h89, 8'h8B: op_class = OP_ALU_RM;
            8'h83:                      op_class = OP_ALU_IMM8;
            8'h81:                      op_class = OP_ALU_IMM;
            // mov r32, imm
            [8'hB8:8'hBF]:              op_class = OP_MOV_IMM;
            8'hEB:                      op_class = OP_JMP_REL8;
            8'hE9:                      op_class = OP_JMP_REL;
            8'h90:                      op_class = OP_NOP;
            default:                    op_class = OP_UNKNOWN;
        endcase
    end

    ////////////////////////////////////////
    // immediate size and modrm presence
    ////////////////////////////////////////

    always_comb begin
        case (op_class)
            OP_ALU_IMM8, OP_JMP_REL8: imm_size = IMM_8;
            // full-width immediate shrinks under 66
            OP_ALU_IMM, OP_MOV_IMM, OP_JMP_REL: begin
                if (is_opsize) begin
                    imm_size = IMM_16;
                end else begin
                    imm_size = IMM_32;
                end
            end
            default: imm_size = IMM_NONE;
        endcase
    end

    assign has_modrm    = op_class inside {OP_ALU_RM, OP_ALU_IMM8, OP_ALU_IMM};
    // register for the B8+r form
    assign opcode_reg   = opcode_byte[2:0];
    assign opcode_known = (op_class != OP_UNKNOWN);

endmodule

`default_nettype wire

// File: src/modrm_decode.sv
`timescale 1ns/10ps
`default_nettype none

`include "decode_macros.svh"

module modrm_decode
    import decode_pkg::*;
(
    input  logic [0:`DEC_PACKET_BYTES-1][7:0] packet_in,
    input  logic [1:0]                        num_prefixes,
    input  logic                              has_modrm,
    input  logic [2:0]                        opcode_reg,
    output logic [2:0]                        reg1,
    output logic [2:0]                        reg2,
    output logic [2:0]                        reg3,
    output logic                              use_reg2,
    output logic                              use_reg3,
    output logic [1:0]                        scale,
    output disp_size_e                        disp_size,
    output logic [2:0]                        modrm_len
);

    logic [3:0] modrm_pos;
    logic [7:0] modrm_byte;
    logic [7:0] sib_byte;
    logic       has_sib;
    logic [2:0] disp_bytes;

    // modrm follows the opcode, sib follows modrm
    assign modrm_pos  = {2'b00, num_prefixes} + 4'd1;
    assign modrm_byte = packet_in[modrm_pos];
    assign sib_byte   = packet_in[modrm_pos + 4'd1];

    // r/m 100 selects sib unless register form
    assign has_sib = has_modrm && (modrm_byte[7:6] != 2'b11) && (modrm_byte[2:0] == 3'b100);

    // reg field, or the register packed in the opcode
    assign reg1 = has_modrm ? modrm_byte[5:3] : opcode_reg;

    ////////////////////////////////////////
    // base, index and displacement
    ////////////////////////////////////////

    always_comb begin
        reg2      = 3'd0;
        reg3      = 3'd0;
        use_reg2  = 1'b0;
        use_reg3  = 1'b0;
        scale     = 2'd0;
        disp_size = DISP_NONE;
        if (has_modrm) begin
            use_reg2 = 1'b1;
            // base comes from sib when present
            reg2     = has_sib ? sib_byte[2:0] : modrm_byte[2:0];
            case (modrm_byte[7:6])
                2'b01: disp_size = DISP_8;
                2'b10: disp_size = DISP_32;
                2'b00: begin
                    // disp32 with no base register
                    if (has_sib ? (sib_byte[2:0] == 3'b101) : (modrm_byte[2:0] == 3'b101)) begin
                        disp_size = DISP_32;
                        use_reg2  = 1'b0;
                    end
                end
                default: disp_size = DISP_NONE;
            endcase
            if (has_sib) begin
                scale    = sib_byte[7:6];
                reg3     = sib_byte[5:3];
                // index 100 means none
                use_reg3 = (sib_byte[5:3] != 3'b100);
            end
        end
    end

    assign disp_bytes = (disp_size == DISP_32) ? 3'd4 :
                        (disp_size == DISP_8)  ? 3'd1 : 3'd0;

    // modrm + sib + displacement
    assign modrm_len = has_modrm ? (3'd1 + {2'b00, has_sib} + disp_bytes) : 3'd0;

endmodule

`default_nettype wire

// File: src/disp_imm_length.sv
`timescale 1ns/10ps
`default_nettype none

`include "decode_macros.svh"

module disp_imm_length
    import decode_pkg::*;
(
    input  logic [0:`DEC_PACKET_BYTES-1][7:0] packet_in,
    input  logic [1:0]                        num_prefixes,
    input  logic                              has_modrm,
    input  logic [2:0]                        modrm_len,
    input  disp_size_e                        disp_size,
    input  imm_size_e                         imm_size,
    input  logic                              opcode_known,
    output logic [31:0]                       disp,
    output logic [31:0]                       imm,
    output logic [`DEC_LEN_WIDTH-1:0]         decoded_len
);

    logic [3:0]                imm_pos;
    logic [3:0]                disp_bytes;
    logic [31:0]               imm_word;
    logic [31:0]               disp_word;
    logic [`DEC_LEN_WIDTH-1:0] imm_bytes;

    // four bytes from pos upward, lowest byte first
    function automatic logic [31:0] le_word(
        input logic [0:`DEC_PACKET_BYTES-1][7:0] pkt,
        input logic [3:0]                        pos
    );
        return {pkt[pos + 4'd3], pkt[pos + 4'd2], pkt[pos + 4'd1], pkt[pos]};
    endfunction

    // immediate starts where the modrm group ends
    assign imm_pos  = {2'b00, num_prefixes} + 4'd1 + {1'b0, modrm_len};
    assign imm_word = le_word(packet_in, imm_pos);

    // displacement is the tail of the modrm group
    assign disp_bytes = (disp_size == DISP_32) ? 4'd4 :
                        (disp_size == DISP_8)  ? 4'd1 : 4'd0;
    assign disp_word  = le_word(packet_in, imm_pos - disp_bytes);

    always_comb begin
        disp = 32'd0;
        if (has_modrm) begin
            case (disp_size)
                // disp8 sign-extended
                DISP_8:  disp = {{24{disp_word[7]}}, disp_word[7:0]};
                DISP_32: disp = disp_word;
                default: disp = 32'd0;
            endcase
        end
    end

    // immediates zero-extended
    always_comb begin
        case (imm_size)
            IMM_8: begin
                imm       = {24'd0, imm_word[7:0]};
                imm_bytes = `DEC_LEN_WIDTH'd1;
            end
            IMM_16: begin
                imm       = {16'd0, imm_word[15:0]};
                imm_bytes = `DEC_LEN_WIDTH'd2;
            end
            IMM_32: begin
                imm       = imm_word;
                imm_bytes = `DEC_LEN_WIDTH'd4;
            end
            default: begin
                imm       = 32'd0;
                imm_bytes = '0;
            end
        endcase
    end

    // unknown opcode reports zero length
    assign decoded_len = opcode_known ? ({{(`DEC_LEN_WIDTH-4){1'b0}}, imm_pos} + imm_bytes) : '0;

endmodule

`default_nettype wire

// File: src/eip_control.sv
`timescale 1ns/10ps
`default_nettype none

`include "decode_macros.svh"

module eip_control (
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic                      valid_in,
    input  logic                      queue_full_stall,
    input  logic                      is_init,
    input  logic [`DEC_EIP_WIDTH-1:0] init_eip,
    input  logic                      is_resteer,
    input  logic [`DEC_EIP_WIDTH-1:0] wb_eip,
    input  logic                      is_br_taken,
    input  logic [`DEC_EIP_WIDTH-1:0] bp_eip,
    input  logic [`DEC_LEN_WIDTH-1:0] decoded_len,
    output logic [`DEC_LEN_WIDTH-1:0] instr_len,
    output logic                      stall_out,
    output logic [`DEC_EIP_WIDTH-1:0] latched_eip,
    output logic [`DEC_EIP_WIDTH-1:0] eip_out
);

    logic                      redirect;
    logic                      load_eip;
    logic [`DEC_EIP_WIDTH-1:0] next_eip;

    // length only counts for a valid packet
    assign instr_len = valid_in ? decoded_len : '0;
    assign eip_out   = latched_eip + {{(`DEC_EIP_WIDTH-`DEC_LEN_WIDTH){1'b0}}, instr_len};

    // back-pressure only with a packet present
    assign stall_out = queue_full_stall & valid_in;

    ////////////////////////////////////////
    // redirect priority
    ////////////////////////////////////////

    assign redirect = is_init | is_resteer | is_br_taken;

    always_comb begin
        if (is_init) begin
            next_eip = init_eip;
        end else if (is_resteer) begin
            next_eip = wb_eip;
        end else if (is_br_taken) begin
            next_eip = bp_eip;
        end else begin
            next_eip = eip_out;
        end
    end

    // stall wins over a redirect
    assign load_eip = (redirect | valid_in) & ~stall_out;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            latched_eip <= '0;
        end else if (load_eip) begin
            latched_eip <= next_eip;
        end
    end

endmodule

`default_nettype wire

// File: src/decode_top.sv
`timescale 1ns/10ps
`default_nettype none

`include "decode_macros.svh"

module decode_top
    import decode_pkg::*;
(
    input  logic                              clk,
    input  logic                              rst_n,
    // fetch side
    input  logic                              valid_in,
    input  logic [0:`DEC_PACKET_BYTES-1][7:0] packet_in,
    input  logic                              queue_full_stall,
    // redirect strobes
    input  logic                              is_init,
    input  logic [`DEC_EIP_WIDTH-1:0]         init_eip,
    input  logic                              is_resteer,
    input  logic [`DEC_EIP_WIDTH-1:0]         wb_eip,
    input  logic                              is_br_taken,
    input  logic [`DEC_EIP_WIDTH-1:0]         bp_eip,
    // decoded fields
    output logic                              valid_out,
    output op_class_e                         op_class,
    output logic                              op_is_16,
    output logic                              is_rep,
    output logic                              is_seg_override,
    output seg_reg_e                          seg_sel,
    output logic [2:0]                        reg1,
    output logic [2:0]                        reg2,
    output logic [2:0]                        reg3,
    output logic                              use_reg2,
    output logic                              use_reg3,
    output logic [1:0]                        scale,
    output logic [31:0]                       disp,
    output logic [31:0]                       imm,
    // length and pointer
    output logic [`DEC_LEN_WIDTH-1:0]         instr_len,
    output logic                              stall_out,
    output logic [`DEC_EIP_WIDTH-1:0]         latched_eip,
    output logic [`DEC_EIP_WIDTH-1:0]         eip_out
);

    logic [1:0]                num_prefixes;
    imm_size_e                 imm_size;
    logic                      has_modrm;
    logic [2:0]                opcode_reg;
    logic                      opcode_known;
    disp_size_e                disp_size;
    logic [2:0]                modrm_len;
    logic [`DEC_LEN_WIDTH-1:0] decoded_len;

    assign valid_out = valid_in;

    ////////////////////////////////////////
    // decoders
    ////////////////////////////////////////

    prefix_decode u_prefix (
        .packet_in       (packet_in),
        .num_prefixes    (num_prefixes),
        .is_rep          (is_rep),
        .is_opsize       (op_is_16),
        .is_seg_override (is_seg_override),
        .seg_sel         (seg_sel)
    );

    opcode_decode u_opcode (
        .packet_in    (packet_in),
        .num_prefixes (num_prefixes),
        .is_opsize    (op_is_16),
        .op_class     (op_class),
        .imm_size     (imm_size),
        .has_modrm    (has_modrm),
        .opcode_reg   (opcode_reg),
        .opcode_known (opcode_known)
    );

    modrm_decode u_modrm (
        .packet_in    (packet_in),
        .num_prefixes (num_prefixes),
        .has_modrm    (has_modrm),
        .opcode_reg   (opcode_reg),
        .reg1         (reg1),
        .reg2         (reg2),
        .reg3         (reg3),
        .use_reg2     (use_reg2),
        .use_reg3     (use_reg3),
        .scale        (scale),
        .disp_size    (disp_size),
        .modrm_len    (modrm_len)
    );

    disp_imm_length u_len (
        .packet_in    (packet_in),
        .num_prefixes (num_prefixes),
        .has_modrm    (has_modrm),
        .modrm_len    (modrm_len),
        .disp_size    (disp_size),
        .imm_size     (imm_size),
        .opcode_known (opcode_known),
        .disp         (disp),
        .imm          (imm),
        .decoded_len  (decoded_len)
    );

    ////////////////////////////////////////
    // pointer tracker
    ////////////////////////////////////////

    eip_control u_eip (
        .clk              (clk),
        .rst_n            (rst_n),
        .valid_in         (valid_in),
        .queue_full_stall (queue_full_stall),
        .is_init          (is_init),
        .init_eip         (init_eip),
        .is_resteer       (is_resteer),
        .wb_eip           (wb_eip),
        .is_br_taken      (is_br_taken),
        .bp_eip           (bp_eip),
        .decoded_len      (decoded_len),
        .instr_len        (instr_len),
        .stall_out        (stall_out),
        .latched_eip      (latched_eip),
        .eip_out          (eip_out)
    );

endmodule

`default_nettype wire

// File: testbench/tb_decode_top.sv
`timescale 1ns/10ps
`default_nettype none

module tb_decode_top;

    localparam int CLK_PERIOD   = 8;
    localparam int RESET_CYCLES = 8;
    localparam int N_RANDOM     = 48;

    logic         clk;
    logic         rst_n;
    logic         valid_in;
    logic [127:0] packet_in;
    logic         queue_full_stall;
    logic         is_init;
    logic [31:0]  init_eip;
    logic         is_resteer;
    logic [31:0]  wb_eip;
    logic         is_br_taken;
    logic [31:0]  bp_eip;

    logic         valid_out;
    logic [2:0]   op_class;
    logic         op_is_16;
    logic         is_rep;
    logic         is_seg_override;
    logic [2:0]   seg_sel;
    logic [2:0]   reg1;
    logic [2:0]   reg2;
    logic [2:0]   reg3;
    logic         use_reg2;
    logic         use_reg3;
    logic [1:0]   scale;
    logic [31:0]  disp;
    logic [31:0]  imm;
    logic [7:0]   instr_len;
    logic         stall_out;
    logic [31:0]  latched_eip;
    logic [31:0]  eip_out;

    // current vector, stimulus half
    logic         cur_valid;
    logic         cur_qf;
    logic         cur_init;
    logic         cur_resteer;
    logic         cur_br;
    logic [31:0]  cur_init_eip;
    logic [31:0]  cur_wb_eip;
    logic [31:0]  cur_bp_eip;
    logic [127:0] cur_packet;
    // current vector, expected half
    logic [31:0]  exp_op;
    logic [31:0]  exp_reg1;
    logic [31:0]  exp_reg2;
    logic [31:0]  exp_reg3;
    logic [31:0]  exp_use2;
    logic [31:0]  exp_use3;
    logic [31:0]  exp_scale;
    logic [31:0]  exp_seg;
    logic [31:0]  exp_disp;
    logic [31:0]  exp_imm;
    logic [31:0]  exp_len;

    string        vec_lines[$];
    logic [31:0]  model_eip;
    integer       seed;
    int           errors;
    int           checks;
    logic         loaded = 1'b0;

    decode_top dut (
        .clk              (clk),
        .rst_n            (rst_n),
        .valid_in         (valid_in),
        .packet_in        (packet_in),
        .queue_full_stall (queue_full_stall),
        .is_init          (is_init),
        .init_eip         (init_eip),
        .is_resteer       (is_resteer),
        .wb_eip           (wb_eip),
        .is_br_taken      (is_br_taken),
        .bp_eip           (bp_eip),
        .valid_out        (valid_out),
        .op_class         (op_class),
        .op_is_16         (op_is_16),
        .is_rep           (is_rep),
        .is_seg_override  (is_seg_override),
        .seg_sel          (seg_sel),
        .reg1             (reg1),
        .reg2             (reg2),
        .reg3             (reg3),
        .use_reg2         (use_reg2),
        .use_reg3         (use_reg3),
        .scale            (scale),
        .disp             (disp),
        .imm              (imm),
        .instr_len        (instr_len),
        .stall_out        (stall_out),
        .latched_eip      (latched_eip),
        .eip_out          (eip_out)
    );

    initial clk = 1'b0;
    always #(CLK_PERIOD / 2) clk = ~clk;

    ////////////////////////////////////////
    // helpers
    ////////////////////////////////////////

    task automatic compare_field(input int idx, input string name,
                                 input logic [31:0] got, input logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("CHECK FAILED %s vector %0d: got 0x%h expected 0x%h", name, idx, got, exp);
        end
    endtask

    // opsize, rep and segment flags from up to three leading bytes
    function automatic logic [2:0] prefix_flags(input logic [127:0] pkt);
        logic [2:0] flags;
        logic [7:0] b;
        flags = 3'b000;
        for (int i = 0; i < 3; i++) begin
            b = pkt[127 - 8 * i -: 8];
            if (b == 8'h66) begin
                flags[2] = 1'b1;
            end else if (b == 8'hF3) begin
                flags[1] = 1'b1;
            end else if (b == 8'h26 || b == 8'h2E || b == 8'h36 ||
                         b == 8'h3E || b == 8'h64 || b == 8'h65) begin
                flags[0] = 1'b1;
            end else begin
                break;
            end
        end
        return flags;
    endfunction

    // one text line into the current vector
    task automatic parse_vector(input string line, output int n);
        n = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                    cur_valid, cur_qf, cur_init, cur_resteer, cur_br,
                    cur_init_eip, cur_wb_eip, cur_bp_eip, cur_packet,
                    exp_op, exp_reg1, exp_reg2, exp_reg3, exp_use2, exp_use3,
                    exp_scale, exp_seg, exp_disp, exp_imm, exp_len);
    endtask

    // drive one cycle, check fields, step the pointer model
    task automatic run_cycle(input int idx);
        logic [31:0] exp_instr_len;
        logic        exp_stall;
        logic [2:0]  exp_flags;
        @(posedge clk);
        #1;
        // result of the previous edge
        compare_field(idx, "latched_eip", latched_eip, model_eip);
        valid_in         = cur_valid;
        queue_full_stall = cur_qf;
        is_init          = cur_init;
        is_resteer       = cur_resteer;
        is_br_taken      = cur_br;
        init_eip         = cur_init_eip;
        wb_eip           = cur_wb_eip;
        bp_eip           = cur_bp_eip;
        packet_in        = cur_packet;
        #5;
        // length only counts for a valid packet
        exp_instr_len = cur_valid ? exp_len : 32'd0;
        exp_stall     = cur_qf & cur_valid;
        exp_flags     = prefix_flags(cur_packet);
        compare_field(idx, "valid_out", {31'd0, valid_out}, {31'd0, cur_valid});
        compare_field(idx, "stall_out", {31'd0, stall_out}, {31'd0, exp_stall});
        compare_field(idx, "op_class", {29'd0, op_class}, exp_op);
        compare_field(idx, "op_is_16", {31'd0, op_is_16}, {31'd0, exp_flags[2]});
        compare_field(idx, "is_rep", {31'd0, is_rep}, {31'd0, exp_flags[1]});
        compare_field(idx, "is_seg_override", {31'd0, is_seg_override},
                      {31'd0, exp_flags[0]});
        compare_field(idx, "reg1", {29'd0, reg1}, exp_reg1);
        compare_field(idx, "reg2", {29'd0, reg2}, exp_reg2);
        compare_field(idx, "reg3", {29'd0, reg3}, exp_reg3);
        compare_field(idx, "use_reg2", {31'd0, use_reg2}, exp_use2);
        compare_field(idx, "use_reg3", {31'd0, use_reg3}, exp_use3);
        compare_field(idx, "scale", {30'd0, scale}, exp_scale);
        compare_field(idx, "seg_sel", {29'd0, seg_sel}, exp_seg);
        compare_field(idx, "disp", disp, exp_disp);
        compare_field(idx, "imm", imm, exp_imm);
        compare_field(idx, "instr_len", {24'd0, instr_len}, exp_instr_len);
        compare_field(idx, "eip_out", eip_out, model_eip + exp_instr_len);
        // stall blocks every load, redirects included
        if (!exp_stall && (cur_init || cur_resteer || cur_br || cur_valid)) begin
            if (cur_init) begin
                model_eip = cur_init_eip;
            end else if (cur_resteer) begin
                model_eip = cur_wb_eip;
            end else if (cur_br) begin
                model_eip = cur_bp_eip;
            end else begin
                model_eip = model_eip + exp_instr_len;
            end
        end
    endtask

    ////////////////////////////////////////
    // main sequence
    ////////////////////////////////////////

    initial begin
        integer      fd;
        string       line;
        int          n;
        logic [31:0] rnd;
        seed             = 1172;
        errors           = 0;
        checks           = 0;
        model_eip        = 32'd0;
        rst_n            = 1'b0;
        valid_in         = 1'b0;
        packet_in        = 128'd0;
        queue_full_stall = 1'b0;
        is_init          = 1'b0;
        init_eip         = 32'd0;
        is_resteer       = 1'b0;
        wb_eip           = 32'd0;
        is_br_taken      = 1'b0;
        bp_eip           = 32'd0;
        fd = $fopen("testbench/decode_tests.txt", "r");
        if (fd == 0) begin
            $display("ERROR: cannot open testbench/decode_tests.txt");
            errors++;
        end else begin
            while (!$feof(fd)) begin
                line = "";
                void'($fgets(line, fd));
                // skip blanks and column notes
                if (line.len() > 1 && line.substr(0, 0) != "#") begin
                    parse_vector(line, n);
                    if (n == 20) begin
                        vec_lines.push_back(line);
                    end else begin
                        $display("ERROR: vector line has %0d of 20 fields: %s", n, line);
                        errors++;
                    end
                end
            end
            $fclose(fd);
            if (vec_lines.size() == 0) begin
                $display("ERROR: the vector file holds no test vectors");
                errors++;
            end
        end
        loaded = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        #1;
        rst_n = 1'b1;
        foreach (vec_lines[i]) begin
            parse_vector(vec_lines[i], n);
            run_cycle(i);
        end
        // random strobes and back-pressure on nop packets
        for (int r = 0; r < N_RANDOM; r++) begin
            rnd          = $random(seed);
            cur_valid    = rnd[0];
            cur_qf       = (rnd[2:1] == 2'b00);
            cur_init     = (rnd[5:3] == 3'b000);
            cur_resteer  = (rnd[8:6] == 3'b000);
            cur_br       = (rnd[10:9] == 2'b00);
            cur_init_eip = $random(seed);
            cur_wb_eip   = $random(seed);
            cur_bp_eip   = $random(seed);
            cur_packet   = {8'h90, 120'd0};
            exp_op       = 32'd6;
            exp_reg1     = 32'd0;
            exp_reg2     = 32'd0;
            exp_reg3     = 32'd0;
            exp_use2     = 32'd0;
            exp_use3     = 32'd0;
            exp_scale    = 32'd0;
            // ds by default
            exp_seg      = 32'd3;
            exp_disp     = 32'd0;
            exp_imm      = 32'd0;
            exp_len      = 32'd1;
            run_cycle(vec_lines.size() + r);
        end
        @(posedge clk);
        #1;
        compare_field(vec_lines.size() + N_RANDOM, "latched_eip", latched_eip, model_eip);
        $display("checks: %0d  errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

    // watchdog, sized from the vector count
    initial begin
        int limit;
        wait (loaded);
        limit = (vec_lines.size() + N_RANDOM + RESET_CYCLES + 20) * CLK_PERIOD;
        #(limit);
        $display("ERROR: timeout, the run did not finish within %0d ns", limit);
        $display("checks: %0d  errors: %0d", checks, errors + 1);
        $display("** FAIL **");
        $finish;
    end

endmodule

`default_nettype wire

// File: testbench/decode_tests.txt
# valid qf init resteer br init_eip wb_eip bp_eip packet(byte 0 first)
# expected: op_class reg1 reg2 reg3 use2 use3 scale seg disp imm len
1 0 1 0 0 1000 0 0 90000000000000000000000000000000 6 0 0 0 0 0 0 3 0 0 1
1 0 0 0 0 0 0 0 01C80000000000000000000000000000 0 1 0 0 1 0 0 3 0 0 2
1 0 0 0 0 0 0 0 8B45F800000000000000000000000000 0 0 5 0 1 0 0 3 fffffff8 0 3
1 0 0 0 0 0 0 0 8B0D7856341200000000000000000000 0 1 5 0 0 0 0 3 12345678 0 6
1 0 0 0 0 0 0 0 8B448E10000000000000000000000000 0 0 6 1 1 1 2 3 10 0 4
1 0 0 0 0 0 0 0 8B048D44332211000000000000000000 0 0 5 1 0 1 2 3 11223344 0 7
1 0 0 0 0 0 0 0 8B042400000000000000000000000000 0 0 4 4 1 0 0 3 0 0 3
1 0 0 0 0 0 0 0 83C00500000000000000000000000000 1 0 0 0 1 0 0 3 0 5 3
1 0 0 0 0 0 0 0 6681C334120000000000000000000000 2 0 3 0 1 0 0 3 0 1234 5
1 0 0 0 0 0 0 0 81C37856341200000000000000000000 2 0 3 0 1 0 0 3 0 12345678 6
1 0 0 0 0 0 0 0 BB443322110000000000000000000000 3 3 0 0 0 0 0 3 0 11223344 5
1 0 0 0 0 0 0 0 66B9CDAB000000000000000000000000 3 1 0 0 0 0 0 3 0 abcd 4
1 0 0 0 0 0 0 0 2E64B801000000000000000000000000 3 0 0 0 0 0 0 4 0 1 7
1 0 0 0 0 0 0 0 F3266590000000000000000000000000 6 0 0 0 0 0 0 5 0 0 4
1 0 0 0 0 0 0 0 EBFE0000000000000000000000000000 4 3 0 0 0 0 0 3 0 fe 2
1 0 0 0 0 0 0 0 E9000100000000000000000000000000 5 1 0 0 0 0 0 3 0 100 5
1 0 0 0 0 0 0 0 0F0B0000000000000000000000000000 7 7 0 0 0 0 0 3 0 0 0
0 0 0 0 0 0 0 0 90000000000000000000000000000000 6 0 0 0 0 0 0 3 0 0 1
1 0 1 1 1 2000 3000 4000 90000000000000000000000000000000 6 0 0 0 0 0 0 3 0 0 1
0 0 0 1 1 0 3000 4000 90000000000000000000000000000000 6 0 0 0 0 0 0 3 0 0 1
1 0 0 0 1 0 0 4000 90000000000000000000000000000000 6 0 0 0 0 0 0 3 0 0 1
1 1 1 0 0 5000 0 0 90000000000000000000000000000000 6 0 0 0 0 0 0 3 0 0 1
0 1 0 0 0 0 0 0 90000000000000000000000000000000 6 0 0 0 0 0 0 3 0 0 1
1 0 0 0 0 0 0 0 90000000000000000000000000000000 6 0 0 0 0 0 0 3 0 0 1

// File: decode_top.f
+incdir+src
src/decode_pkg.sv
src/prefix_decode.sv
src/opcode_decode.sv
src/modrm_decode.sv
src/disp_imm_length.sv
src/eip_control.sv
src/decode_top.sv
testbench/tb_decode_top.sv

// File: Makefile
VERILATOR   ?= verilator
TOP         := tb_decode_top
RTL_TOP     := decode_top
FILELIST    := decode_top.f
BUILD_FLAGS := --binary --timing -Wno-fatal -j 0
LINT_FLAGS  := --lint-only --timing -Wall
OBJ_DIR     := obj_dir
LOG         := sim.log

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(BUILD_FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: build
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -qF '** FAIL **' $(LOG); then echo "simulation failed"; exit 1; fi
	@grep -qF '** PASS **' $(LOG) || { echo "no result found in $(LOG)"; exit 1; }
	@echo "simulation passed"

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
